/* rtl/cpu_pkg.sv */
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  reg_idx_t;

  // Primary opcode, inst[31:26]
  typedef enum logic [5:0] {
    OP1_ALUR = 6'b000000,
    OP1_BEQ  = 6'b001000,
    OP1_BLT  = 6'b001001,
    OP1_BLE  = 6'b001010,
    OP1_BNE  = 6'b001011,
    OP1_JAL  = 6'b001100,
    OP1_LW   = 6'b010010,
    OP1_SW   = 6'b011010,
    OP1_ADDI = 6'b100000,
    OP1_ANDI = 6'b100100,
    OP1_ORI  = 6'b100101,
    OP1_XORI = 6'b100110
  } op1_e;

  // ALU function for OP1_ALUR, inst[25:18]
  typedef enum logic [7:0] {
    OP2_EQ   = 8'b00001000,
    OP2_LT   = 8'b00001001,
    OP2_LE   = 8'b00001010,
    OP2_NE   = 8'b00001011,
    OP2_ADD  = 8'b00100000,
    OP2_AND  = 8'b00100100,
    OP2_OR   = 8'b00100101,
    OP2_XOR  = 8'b00100110,
    OP2_SUB  = 8'b00101000,
    OP2_NAND = 8'b00101100,
    OP2_NOR  = 8'b00101101,
    OP2_XNOR = 8'b00101110,
    OP2_RSHF = 8'b00110000, // Arithmetic right shift
    OP2_LSHF = 8'b00110001
  } op2_e;

  // Second ALU operand
  typedef enum logic [1:0] {
    ALU_SRC_RT   = 2'd0,
    ALU_SRC_IMM  = 2'd1,
    ALU_SRC_IMM4 = 2'd2  // Immediate times four
  } alu_src_e;

  typedef enum logic [1:0] {
    WB_PC  = 2'd0,
    WB_MEM = 2'd1,
    WB_ALU = 2'd2
  } wb_src_e;

  localparam word_t INST_SIZE = 32'd4;

  // Memory-mapped I/O, everything from ADDR_HEX upward
  localparam word_t ADDR_HEX  = 32'hFFFF_F000;
  localparam word_t ADDR_LEDR = 32'hFFFF_F020;
  localparam word_t ADDR_KEY  = 32'hFFFF_F080;

  localparam int HEX_W  = 24;
  localparam int LEDR_W = 10;
  localparam int KEY_W  = 4;

  localparam logic [HEX_W-1:0] HEX_RESET = 24'hFEDEAD;

endpackage

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
  parameter cpu_pkg::word_t START_PC = 32'h0000_0100
) (
  input  logic           clk,
  input  logic           reset,
  output cpu_pkg::word_t imem_addr,
  input  cpu_pkg::word_t imem_data,
  input  logic           hazard_stall,
  input  logic           flow_hold,
  input  logic           redirect,
  input  cpu_pkg::word_t redirect_pc,
  output cpu_pkg::word_t inst_fd,
  output cpu_pkg::word_t pc_next_fd
);
  import cpu_pkg::*;

  word_t pc;
  word_t pc_plus;

  assign pc_plus   = pc + INST_SIZE;
  assign imem_addr = pc; // Instruction memory answers in the same cycle

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc      <= START_PC;
      inst_fd <= '0;
    end else if (redirect) begin
      pc      <= redirect_pc;
      inst_fd <= '0;        // Word at the held PC is wrong path
    end else if (!hazard_stall) begin
      if (flow_hold) begin
        inst_fd <= '0;      // PC stays on the return address of the branch
      end else begin
        pc      <= pc_plus;
        inst_fd <= imem_data;
      end
    end
  end

  // Return address travels with the instruction
  always_ff @(posedge clk) begin
    if (!hazard_stall)
      pc_next_fd <= pc_plus;
  end

endmodule

/* rtl/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit (
  input  logic                clk,
  input  logic                reset,
  input  cpu_pkg::word_t      inst_fd,
  input  cpu_pkg::word_t      pc_next_fd,
  output cpu_pkg::reg_idx_t   rs_idx,
  output cpu_pkg::reg_idx_t   rt_idx,
  input  cpu_pkg::word_t      rs_val,
  input  cpu_pkg::word_t      rt_val,
  input  logic                ex_reg_we,
  input  cpu_pkg::reg_idx_t   ex_dst,
  input  logic                mem_reg_we,
  input  cpu_pkg::reg_idx_t   mem_dst,
  input  logic                wb_reg_we,
  input  cpu_pkg::reg_idx_t   wb_dst,
  output logic                hazard_stall,
  output logic                flow_hold,
  output cpu_pkg::op1_e       de_op1,
  output cpu_pkg::op2_e       de_op2,
  output cpu_pkg::alu_src_e   de_alu_src,
  output cpu_pkg::wb_src_e    de_wb_src,
  output logic                de_mem_we,
  output logic                de_reg_we,
  output cpu_pkg::reg_idx_t   de_dst,
  output cpu_pkg::word_t      de_rs_val,
  output cpu_pkg::word_t      de_rt_val,
  output cpu_pkg::word_t      de_imm,
  output cpu_pkg::word_t      de_pc_next
);
  import cpu_pkg::*;

  logic [5:0]  op1_raw;
  logic [7:0]  op2_raw;
  logic [15:0] imm;
  reg_idx_t    rd_idx;
  reg_idx_t    dst;
  logic        valid;        // Known opcode, else treated as bubble
  logic        uses_rt;
  logic        is_flow;      // Branch or jal
  logic        dst_is_rd;
  logic        mem_we;
  logic        reg_we;
  alu_src_e    alu_src;
  wb_src_e     wb_src;
  logic        rs_hit;
  logic        rt_hit;
  logic        kill;

  assign op1_raw = inst_fd[31:26];
  assign op2_raw = inst_fd[25:18];
  assign imm     = inst_fd[23:8];
  assign rd_idx  = inst_fd[11:8];
  assign rs_idx  = inst_fd[7:4];
  assign rt_idx  = inst_fd[3:0];
  assign dst     = dst_is_rd ? rd_idx : rt_idx;

  // Control table
  always_comb begin
    valid     = 1'b1;
    uses_rt   = 1'b0;
    is_flow   = 1'b0;
    dst_is_rd = 1'b0;
    mem_we    = 1'b0;
    reg_we    = 1'b1;
    alu_src   = ALU_SRC_IMM;
    wb_src    = WB_ALU;
    case (op1_raw)
      OP1_ALUR: begin
        alu_src   = ALU_SRC_RT;
        uses_rt   = 1'b1;
        dst_is_rd = 1'b1;
        // All-zero word lands here and falls out as a bubble
        case (op2_raw)
          OP2_EQ, OP2_LT, OP2_LE, OP2_NE, OP2_ADD, OP2_AND, OP2_OR,
          OP2_XOR, OP2_SUB, OP2_NAND, OP2_NOR, OP2_XNOR, OP2_RSHF,
          OP2_LSHF: valid = 1'b1;
          default:  valid = 1'b0;
        endcase
      end
      OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE: begin
        alu_src = ALU_SRC_RT;
        uses_rt = 1'b1;
        is_flow = 1'b1;
        reg_we  = 1'b0;
      end
      OP1_JAL: begin
        alu_src = ALU_SRC_IMM4;
        is_flow = 1'b1;
        wb_src  = WB_PC;    // Link value into rt
      end
      OP1_LW: wb_src = WB_MEM;
      OP1_SW: begin
        uses_rt = 1'b1;
        mem_we  = 1'b1;
        reg_we  = 1'b0;
      end
      OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI: valid = 1'b1;
      default: begin
        valid  = 1'b0;
        reg_we = 1'b0;
      end
    endcase
  end

  // Producers in execute, memory and write-back; r0 never waits
  assign rs_hit = (rs_idx != '0) &&
                  ((de_reg_we && rs_idx == de_dst) || (ex_reg_we && rs_idx == ex_dst) ||
                   (mem_reg_we && rs_idx == mem_dst) || (wb_reg_we && rs_idx == wb_dst));
  assign rt_hit = (rt_idx != '0) &&
                  ((de_reg_we && rt_idx == de_dst) || (ex_reg_we && rt_idx == ex_dst) ||
                   (mem_reg_we && rt_idx == mem_dst) || (wb_reg_we && rt_idx == wb_dst));

  assign hazard_stall = valid && (rs_hit || (uses_rt && rt_hit));
  assign flow_hold    = valid && is_flow && !hazard_stall;
  assign kill         = hazard_stall || !valid;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      de_op1     <= OP1_ALUR;
      de_op2     <= OP2_ADD;
      de_alu_src <= ALU_SRC_RT;
      de_wb_src  <= WB_ALU;
      de_mem_we  <= 1'b0;
      de_reg_we  <= 1'b0;
      de_dst     <= '0;
    end else begin
      de_op1     <= kill ? OP1_ALUR : op1_e'(op1_raw);
      de_op2     <= kill ? OP2_ADD : op2_e'(op2_raw);
      de_alu_src <= alu_src;
      de_wb_src  <= wb_src;
      de_mem_we  <= mem_we && !kill;
      de_reg_we  <= reg_we && !kill;
      de_dst     <= dst;
    end
  end

  always_ff @(posedge clk) begin
    de_rs_val  <= rs_val;
    de_rt_val  <= rt_val;
    de_imm     <= {{16{imm[15]}}, imm}; // Sign extension
    de_pc_next <= pc_next_fd;
  end

endmodule

/* rtl/register_file.sv */
`timescale 1ns/1ps

module register_file (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::reg_idx_t rs_idx,
  input  cpu_pkg::reg_idx_t rt_idx,
  output cpu_pkg::word_t    rs_val,
  output cpu_pkg::word_t    rt_val,
  input  logic              wb_reg_we,
  input  cpu_pkg::reg_idx_t wb_dst,
  input  cpu_pkg::word_t    wb_data
);
  import cpu_pkg::*;

  word_t regs [16];

  assign rs_val = regs[rs_idx];
  assign rt_val = regs[rt_idx];

  // Falling-edge write, so decode reads the new value in the same cycle
  always_ff @(negedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 16; i++)
        regs[i] <= '0;
    end else if (wb_reg_we) begin
      regs[wb_dst] <= wb_data;
    end
  end

endmodule

/* rtl/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::op1_e     de_op1,
  input  cpu_pkg::op2_e     de_op2,
  input  cpu_pkg::alu_src_e de_alu_src,
  input  cpu_pkg::wb_src_e  de_wb_src,
  input  logic              de_mem_we,
  input  logic              de_reg_we,
  input  cpu_pkg::reg_idx_t de_dst,
  input  cpu_pkg::word_t    de_rs_val,
  input  cpu_pkg::word_t    de_rt_val,
  input  cpu_pkg::word_t    de_imm,
  input  cpu_pkg::word_t    de_pc_next,
  output logic              redirect,
  output cpu_pkg::word_t    redirect_pc,
  output cpu_pkg::word_t    ex_alu_out,
  output cpu_pkg::word_t    ex_rt_val,
  output cpu_pkg::word_t    ex_pc_next,
  output cpu_pkg::wb_src_e  ex_wb_src,
  output logic              ex_mem_we,
  output logic              ex_reg_we,
  output cpu_pkg::reg_idx_t ex_dst
);
  import cpu_pkg::*;

  word_t a;
  word_t b;
  word_t offset;
  word_t alu_out;
  logic  taken;

  assign a      = de_rs_val;
  assign offset = de_imm << 2;

  always_comb begin
    case (de_alu_src)
      ALU_SRC_IMM:  b = de_imm;
      ALU_SRC_IMM4: b = offset;
      default:      b = de_rt_val;
    endcase
  end

  always_comb begin
    alu_out = '0;
    case (de_op1)
      OP1_ALUR: begin
        case (de_op2)
          OP2_EQ:   alu_out = word_t'(a == b);
          OP2_LT:   alu_out = word_t'($signed(a) < $signed(b));
          OP2_LE:   alu_out = word_t'($signed(a) <= $signed(b));
          OP2_NE:   alu_out = word_t'(a != b);
          OP2_ADD:  alu_out = a + b;
          OP2_AND:  alu_out = a & b;
          OP2_OR:   alu_out = a | b;
          OP2_XOR:  alu_out = a ^ b;
          OP2_SUB:  alu_out = a - b;
          OP2_NAND: alu_out = ~(a & b);
          OP2_NOR:  alu_out = ~(a | b);
          OP2_XNOR: alu_out = ~(a ^ b);
          OP2_RSHF: alu_out = $signed(a) >>> b[4:0];
          OP2_LSHF: alu_out = a << b[4:0];
          default:  alu_out = '0;
        endcase
      end
      OP1_LW, OP1_SW, OP1_ADDI: alu_out = a + b; // Address or sum
      OP1_ANDI: alu_out = a & b;
      OP1_ORI:  alu_out = a | b;
      OP1_XORI: alu_out = a ^ b;
      default:  alu_out = '0;
    endcase
  end

  // Signed branch compare on rs and rt
  always_comb begin
    case (de_op1)
      OP1_BEQ: taken = (a == de_rt_val);
      OP1_BLT: taken = ($signed(a) < $signed(de_rt_val));
      OP1_BLE: taken = ($signed(a) <= $signed(de_rt_val));
      OP1_BNE: taken = (a != de_rt_val);
      default: taken = 1'b0;
    endcase
  end

  assign redirect    = taken || (de_op1 == OP1_JAL);
  assign redirect_pc = ((de_op1 == OP1_JAL) ? a : de_pc_next) + offset;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_wb_src <= WB_PC;
      ex_mem_we <= 1'b0;
      ex_reg_we <= 1'b0;
      ex_dst    <= '0;
    end else begin
      ex_wb_src <= de_wb_src;
      ex_mem_we <= de_mem_we;
      ex_reg_we <= de_reg_we;
      ex_dst    <= de_dst;
    end
  end

  always_ff @(posedge clk) begin
    ex_alu_out <= alu_out;
    ex_rt_val  <= de_rt_val;  // Store data
    ex_pc_next <= de_pc_next;
  end

endmodule

/* rtl/memory_io.sv */
`timescale 1ns/1ps

module memory_io #(
  parameter int DMEM_WORDS = 1024
) (
  input  logic                        clk,
  input  logic                        reset,
  input  cpu_pkg::word_t              ex_alu_out,
  input  cpu_pkg::word_t              ex_rt_val,
  input  cpu_pkg::word_t              ex_pc_next,
  input  cpu_pkg::wb_src_e            ex_wb_src,
  input  logic                        ex_mem_we,
  input  logic                        ex_reg_we,
  input  cpu_pkg::reg_idx_t           ex_dst,
  input  logic [cpu_pkg::KEY_W-1:0]   key,
  output logic [cpu_pkg::HEX_W-1:0]   hex_value,
  output logic [cpu_pkg::LEDR_W-1:0]  ledr_value,
  output logic                        mem_reg_we,
  output cpu_pkg::reg_idx_t           mem_dst,
  output logic                        wb_reg_we,
  output cpu_pkg::reg_idx_t           wb_dst,
  output cpu_pkg::word_t              wb_data
);
  import cpu_pkg::*;

  localparam int IDX_W = $clog2(DMEM_WORDS);

  word_t   dmem [DMEM_WORDS];
  word_t   word_addr;
  logic    is_io;
  word_t   load_data;
  word_t   wb_alu;
  word_t   wb_mem;
  word_t   wb_pc;
  wb_src_e wb_src;

  assign is_io     = (ex_alu_out >= ADDR_HEX);
  assign word_addr = (ex_alu_out >> 2) % DMEM_WORDS;

  // Memory-stage destination for the hazard check
  assign mem_reg_we = ex_reg_we;
  assign mem_dst    = ex_dst;

  always_comb begin
    if (ex_alu_out == ADDR_KEY)
      load_data = {{(32-KEY_W){1'b0}}, ~key}; // KEY is active low
    else if (is_io)
      load_data = '0;
    else
      load_data = dmem[word_addr[IDX_W-1:0]];
  end

  always_ff @(posedge clk) begin
    if (ex_mem_we && !is_io)
      dmem[word_addr[IDX_W-1:0]] <= ex_rt_val;
  end

  // Output registers
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex_value  <= HEX_RESET;
      ledr_value <= '0;
    end else if (ex_mem_we) begin
      if (ex_alu_out == ADDR_HEX)
        hex_value <= ex_rt_val[HEX_W-1:0];
      if (ex_alu_out == ADDR_LEDR)
        ledr_value <= ex_rt_val[LEDR_W-1:0];
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_src    <= WB_PC;
      wb_reg_we <= 1'b0;
      wb_dst    <= '0;
    end else begin
      wb_src    <= ex_wb_src;
      wb_reg_we <= ex_reg_we;
      wb_dst    <= ex_dst;
    end
  end

  always_ff @(posedge clk) begin
    wb_alu <= ex_alu_out;
    wb_mem <= load_data;
    wb_pc  <= ex_pc_next;
  end

  always_comb begin
    case (wb_src)
      WB_PC:   wb_data = wb_pc;   // jal link
      WB_MEM:  wb_data = wb_mem;
      default: wb_data = wb_alu;
    endcase
  end

endmodule

/* rtl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
  parameter cpu_pkg::word_t START_PC   = 32'h0000_0100,
  parameter int             DMEM_WORDS = 1024
) (
  input  logic                       clk,
  input  logic                       reset,
  output cpu_pkg::word_t             imem_addr,
  input  cpu_pkg::word_t             imem_data,
  input  logic [cpu_pkg::KEY_W-1:0]  key,
  output logic [cpu_pkg::HEX_W-1:0]  hex_value,
  output logic [cpu_pkg::LEDR_W-1:0] ledr_value
);
  import cpu_pkg::*;

  // Fetch to decode
  word_t    inst_fd;
  word_t    pc_next_fd;
  logic     hazard_stall;
  logic     flow_hold;
  logic     redirect;
  word_t    redirect_pc;

  // Register file read ports
  reg_idx_t rs_idx;
  reg_idx_t rt_idx;
  word_t    rs_val;
  word_t    rt_val;

  // Decode to execute
  op1_e     de_op1;
  op2_e     de_op2;
  alu_src_e de_alu_src;
  wb_src_e  de_wb_src;
  logic     de_mem_we;
  logic     de_reg_we;
  reg_idx_t de_dst;
  word_t    de_rs_val;
  word_t    de_rt_val;
  word_t    de_imm;
  word_t    de_pc_next;

  // Execute to memory
  word_t    ex_alu_out;
  word_t    ex_rt_val;
  word_t    ex_pc_next;
  wb_src_e  ex_wb_src;
  logic     ex_mem_we;
  logic     ex_reg_we;
  reg_idx_t ex_dst;

  // Memory and write-back
  logic     mem_reg_we;
  reg_idx_t mem_dst;
  logic     wb_reg_we;
  reg_idx_t wb_dst;
  word_t    wb_data;

  fetch_unit #(.START_PC(START_PC)) fetch_i (
    .clk, .reset, .imem_addr, .imem_data, .hazard_stall, .flow_hold,
    .redirect, .redirect_pc, .inst_fd, .pc_next_fd
  );

  decode_unit decode_i (
    .clk, .reset, .inst_fd, .pc_next_fd, .rs_idx, .rt_idx, .rs_val, .rt_val,
    .ex_reg_we, .ex_dst, .mem_reg_we, .mem_dst, .wb_reg_we, .wb_dst,
    .hazard_stall, .flow_hold, .de_op1, .de_op2, .de_alu_src, .de_wb_src,
    .de_mem_we, .de_reg_we, .de_dst, .de_rs_val, .de_rt_val, .de_imm, .de_pc_next
  );

  register_file regfile_i (
    .clk, .reset, .rs_idx, .rt_idx, .rs_val, .rt_val, .wb_reg_we, .wb_dst, .wb_data
  );

  execute_unit execute_i (
    .clk, .reset, .de_op1, .de_op2, .de_alu_src, .de_wb_src, .de_mem_we,
    .de_reg_we, .de_dst, .de_rs_val, .de_rt_val, .de_imm, .de_pc_next,
    .redirect, .redirect_pc, .ex_alu_out, .ex_rt_val, .ex_pc_next,
    .ex_wb_src, .ex_mem_we, .ex_reg_we, .ex_dst
  );

  memory_io #(.DMEM_WORDS(DMEM_WORDS)) memory_i (
    .clk, .reset, .ex_alu_out, .ex_rt_val, .ex_pc_next, .ex_wb_src, .ex_mem_we,
    .ex_reg_we, .ex_dst, .key, .hex_value, .ledr_value, .mem_reg_we, .mem_dst,
    .wb_reg_we, .wb_dst, .wb_data
  );

endmodule

/* verif/cpu_properties.sv */
`timescale 1ns/1ps

module cpu_properties (
  input logic                      clk,
  input logic                      reset,
  input cpu_pkg::word_t            imem_addr,
  input logic [cpu_pkg::HEX_W-1:0] hex_value,
  input logic                      ex_mem_we,
  input logic                      wb_reg_we,
  input logic                      hazard_stall,
  input logic                      flow_hold,
  input logic                      redirect
);
  import cpu_pkg::*;

  fetch_aligned: assert property (@(posedge clk) disable iff (reset)
    imem_addr[1:0] == 2'b00)
    else $error("imem_addr %h is not word aligned", imem_addr);

  // HEX only moves at the edge that ends a store in memory
  hex_after_store: assert property (@(posedge clk) disable iff (reset)
    $changed(hex_value) |-> $past(ex_mem_we))
    else $error("hex_value changed without a store");

  // Stall bubble enters execute, so it reaches write-back three cycles later
  bubble_no_write: assert property (@(posedge clk) disable iff (reset)
    $past(hazard_stall, 3) |-> !wb_reg_we)
    else $error("stall bubble reached write-back with a write enable");

  // Fetch bubble enters decode first
  flow_bubble_no_write: assert property (@(posedge clk) disable iff (reset)
    $past(flow_hold || redirect, 4) |-> !wb_reg_we)
    else $error("fetch bubble reached write-back with a write enable");

endmodule

bind cpu_top cpu_properties props_i (.*);

/* verif/cpu_ref_model.svh */
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// Instruction-level model of the core, one instruction per step
word_t            m_regs [16];
word_t            m_dmem [int];
logic [HEX_W-1:0]  m_hex;
logic [LEDR_W-1:0] m_ledr;

function automatic word_t alu_result(input op2_e f, input word_t a, input word_t b);
  case (f)
    OP2_EQ:   return {31'd0, a == b};
    OP2_LT:   return {31'd0, $signed(a) < $signed(b)};
    OP2_LE:   return {31'd0, $signed(a) <= $signed(b)};
    OP2_NE:   return {31'd0, a != b};
    OP2_ADD:  return a + b;
    OP2_AND:  return a & b;
    OP2_OR:   return a | b;
    OP2_XOR:  return a ^ b;
    OP2_SUB:  return a - b;
    OP2_NAND: return ~(a & b);
    OP2_NOR:  return ~(a | b);
    OP2_XNOR: return ~(a ^ b);
    OP2_RSHF: return $signed(a) >>> b[4:0];
    OP2_LSHF: return a << b[4:0];
    default:  return '0;
  endcase
endfunction

function automatic word_t load_word(input word_t addr, input logic [KEY_W-1:0] k);
  int idx;
  idx = int'((addr >> 2) % DMEM_WORDS);
  if (addr == ADDR_KEY)
    return {{(32-KEY_W){1'b0}}, ~k}; // Pressed keys read as ones
  if (addr >= ADDR_HEX)
    return '0;
  return m_dmem.exists(idx) ? m_dmem[idx] : '0;
endfunction

task automatic store_word(input word_t addr, input word_t data);
  if (addr == ADDR_HEX)
    m_hex = data[HEX_W-1:0];
  else if (addr == ADDR_LEDR)
    m_ledr = data[LEDR_W-1:0];
  else if (addr < ADDR_HEX)
    m_dmem[int'((addr >> 2) % DMEM_WORDS)] = data;
endtask

task automatic run_model(input logic [KEY_W-1:0] k);
  word_t pc;
  word_t inst;
  word_t a;
  word_t b;
  word_t imm;
  int    steps;
  for (int i = 0; i < 16; i++)
    m_regs[i] = '0;
  m_dmem.delete();
  m_hex  = HEX_RESET;
  m_ledr = '0;
  pc     = START_PC;
  steps  = 0;
  while (pc != halt_addr && steps < 5000) begin
    inst  = imem[(pc - START_PC) >> 2];
    imm   = {{16{inst[23]}}, inst[23:8]};
    a     = m_regs[inst[7:4]];
    b     = m_regs[inst[3:0]];
    pc    = pc + INST_SIZE;
    steps = steps + 1;
    case (op1_e'(inst[31:26]))
      OP1_ALUR: m_regs[inst[11:8]] = alu_result(op2_e'(inst[25:18]), a, b);
      OP1_ADDI: m_regs[inst[3:0]] = a + imm;
      OP1_ANDI: m_regs[inst[3:0]] = a & imm;
      OP1_ORI:  m_regs[inst[3:0]] = a | imm;
      OP1_XORI: m_regs[inst[3:0]] = a ^ imm;
      OP1_LW:   m_regs[inst[3:0]] = load_word(a + imm, k);
      OP1_SW:   store_word(a + imm, b);
      OP1_BEQ:  if (a == b) pc = pc + (imm << 2);
      OP1_BLT:  if ($signed(a) < $signed(b)) pc = pc + (imm << 2);
      OP1_BLE:  if ($signed(a) <= $signed(b)) pc = pc + (imm << 2);
      OP1_BNE:  if (a != b) pc = pc + (imm << 2);
      OP1_JAL: begin
        m_regs[inst[3:0]] = pc; // Link is the return address
        pc = a + (imm << 2);
      end
      default: ;
    endcase
  end
endtask

`endif

/* verif/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
  import cpu_pkg::*;

  localparam word_t START_PC   = 32'h0000_0100;
  localparam int    DMEM_WORDS = 1024;
  localparam int    IMEM_WORDS = 512;
  localparam int    HALT_LIMIT = 4000; // Cycles allowed to reach the halt

  logic              clk;
  logic              reset;
  word_t             imem_addr;
  word_t             imem_data;
  logic [KEY_W-1:0]  key;
  logic [HEX_W-1:0]  hex_value;
  logic [LEDR_W-1:0] ledr_value;

  word_t imem [IMEM_WORDS];
  int    prog_len;
  word_t halt_addr;
  int    errors;
  int    seed = 32'hcc18;

  `include "cpu_ref_model.svh"

  cpu_top #(.START_PC(START_PC), .DMEM_WORDS(DMEM_WORDS)) dut_i (
    .clk, .reset, .imem_addr, .imem_data, .key, .hex_value, .ledr_value
  );

  always #2 clk = ~clk;

  function automatic word_t fetch_word(input word_t addr);
    word_t idx;
    idx = (addr - START_PC) >> 2;
    if (addr < START_PC || idx >= IMEM_WORDS)
      return '0; // Outside the program reads as a bubble
    return imem[idx];
  endfunction

  assign imem_data = fetch_word(imem_addr);

  function automatic int rnd(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic int pick_reg();
    return 1 + rnd(12); // r13 and r14 carry I/O addresses
  endfunction

  function automatic word_t enc_r(input op2_e f, input int rd, input int rs, input int rt);
    return {OP1_ALUR, f, 6'd0, rd[3:0], rs[3:0], rt[3:0]};
  endfunction

  function automatic word_t enc_i(input op1_e op, input logic [15:0] imm, input int rs,
                                  input int rt);
    return {op, 2'b00, imm, rs[3:0], rt[3:0]};
  endfunction

  task automatic emit(input word_t w);
    imem[prog_len] = w;
    prog_len = prog_len + 1;
  endtask

  task automatic check_value(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      errors = errors + 1;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Final stores to HEX and LEDR followed by the halt loop
  task automatic emit_tail(input int hx, input int lx);
    emit(enc_i(OP1_ADDI, 16'hF000, 0, 14));
    emit(enc_i(OP1_ADDI, 16'hF020, 0, 13));
    emit(enc_i(OP1_SW, 16'h0000, 14, hx));
    emit(enc_i(OP1_SW, 16'h0000, 13, lx));
    emit(enc_i(OP1_BEQ, 16'hFFFF, 0, 0));
    halt_addr = START_PC + 4 * (prog_len - 1);
  endtask

  task automatic build_program(input int kind);
    op2_e  fns [14] = '{OP2_EQ, OP2_LT, OP2_LE, OP2_NE, OP2_ADD, OP2_AND, OP2_OR,
                        OP2_XOR, OP2_SUB, OP2_NAND, OP2_NOR, OP2_XNOR, OP2_RSHF, OP2_LSHF};
    op1_e  imm_ops [4] = '{OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI};
    op1_e  br_ops [4] = '{OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE};
    word_t written [$];
    int    prev;
    int    dst;
    int    skip;
    int    sel;
    int    fn_idx;
    logic [15:0] addr;
    for (int i = 0; i < IMEM_WORDS; i++)
      imem[i] = '0;
    prog_len = 0;
    fn_idx   = 0;
    // Small values in the branch program so that compares often match
    for (int r = 1; r <= 12; r++)
      emit(enc_i(OP1_ADDI, (kind == 2) ? 16'(rnd(9) - 4) : 16'(rnd(65536)), 0, r));
    prev = pick_reg();
    case (kind)
      0: for (int i = 0; i < 42; i++) begin
        dst = pick_reg();
        if (i % 3 == 2) begin
          emit(enc_i(imm_ops[(i / 3) % 4], 16'(rnd(65536)), prev, dst));
        end else begin
          emit(enc_r(fns[fn_idx % 14], dst, rnd(2) ? prev : pick_reg(), pick_reg()));
          fn_idx = fn_idx + 1;
        end
        prev = dst; // Next instruction often depends on this one
      end
      1: for (int i = 0; i < 30; i++) begin
        sel = (written.size() == 0) ? 0 : rnd(3);
        if (sel == 0) begin
          addr = 16'(4 * rnd(32));
          emit(enc_i(OP1_SW, addr, 0, pick_reg()));
          written.push_back(word_t'(addr));
        end else if (sel == 1) begin
          dst = pick_reg();
          emit(enc_i(OP1_LW, 16'(written[rnd(written.size())]), 0, dst));
          if (rnd(2)) begin
            addr = 16'(4 * rnd(32));
            emit(enc_i(OP1_SW, addr, 0, dst)); // Store of the value just loaded
            written.push_back(word_t'(addr));
          end else begin
            emit(enc_r(OP2_ADD, pick_reg(), dst, dst));
          end
        end else begin
          emit(enc_i(OP1_ADDI, 16'(rnd(65536)), pick_reg(), pick_reg()));
        end
      end
      2: for (int i = 0; i < 16; i++) begin
        sel  = i % 5;
        skip = rnd(3);
        dst  = pick_reg();
        if (sel < 4)
          emit(enc_i(br_ops[sel], 16'(skip), pick_reg(), pick_reg()));
        else
          emit(enc_i(OP1_JAL, 16'((START_PC >> 2) + prog_len + 1 + skip), 0, dst));
        for (int s = 0; s <= skip; s++)
          emit(enc_i(OP1_ADDI, 16'(rnd(3) - 1), pick_reg(), pick_reg()));
        if (sel == 4) begin
          emit(enc_i(OP1_ADDI, 16'hF000, 0, 14));
          emit(enc_i(OP1_SW, 16'h0000, 14, dst)); // Link value to HEX
        end
      end
      default: begin
        emit(enc_r(OP2_XOR, 3, 1, 2));
        emit(enc_i(OP1_ADDI, 16'hF080, 0, 13));
        emit(enc_i(OP1_LW, 16'h0000, 13, 5));
      end
    endcase
    emit_tail(pick_reg(), (kind == 3) ? 5 : pick_reg());
  endtask

  task automatic reset_dut(input logic [KEY_W-1:0] k);
    @(posedge clk);
    reset <= 1'b1;
    key   <= k;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("hex_value after reset", word_t'(hex_value), word_t'(HEX_RESET));
    check_value("ledr_value after reset", word_t'(ledr_value), '0);
    check_value("imem_addr after reset", imem_addr, START_PC);
    @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic wait_halt();
    int cycles;
    cycles = 0;
    while (imem_addr != halt_addr && cycles < HALT_LIMIT) begin
      @(negedge clk);
      cycles = cycles + 1;
    end
    if (imem_addr != halt_addr) begin
      $display("Timeout: the core did not reach the halt address %h", halt_addr);
      $display("Test failed");
      $finish;
    end
  endtask

  task automatic run_program(input int kind);
    logic [KEY_W-1:0] k;
    k = (kind == 3) ? KEY_W'(rnd(16)) : '1;
    build_program(kind);
    run_model(k);
    reset_dut(k);
    wait_halt();
    repeat (10) begin
      @(negedge clk);
      check_value("imem_addr near halt",
                  word_t'(imem_addr == halt_addr || imem_addr == halt_addr + 4), 32'd1);
    end
    check_value("hex_value", word_t'(hex_value), word_t'(m_hex));
    check_value("ledr_value", word_t'(ledr_value), word_t'(m_ledr));
    for (int r = 0; r < 16; r++)
      check_value($sformatf("r%0d", r), dut_i.regfile_i.regs[r], m_regs[r]);
    if (kind == 3)
      check_value("ledr_value from KEY", word_t'(ledr_value), {{(32-KEY_W){1'b0}}, ~k});
  endtask

  initial begin
    clk    = 1'b0;
    reset  = 1'b1;
    key    = '1;
    errors = 0;
    for (int p = 0; p < 4; p++)
      run_program(p);
    $display("Checks finished with %0d errors", errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* pipe_cpu.f */
+incdir+verif
rtl/cpu_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/register_file.sv
rtl/execute_unit.sv
rtl/memory_io.sv
rtl/cpu_top.sv
verif/cpu_properties.sv
verif/cpu_tb.sv

/* Makefile */
# Verilator flow for pipe_cpu

SIM = obj_dir/sim_cpu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module cpu_tb -f pipe_cpu.f -o sim_cpu

run: compile
	./$(SIM) > run.log 2>&1 || true
	cat run.log
	@if grep -q "Test failed" run.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "Test completed successfully" run.log

clean:
	rm -rf obj_dir run.log
